// File: src/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Data path and address width
`define XLEN 32

// Register index width
`define GPR_W 5

// Decode queue entries, also the decoder's credits after reset
`define DQ_DEPTH 4

// Credits granted by the execute side after reset
`define EXEC_CREDITS 2

`endif

// File: src/isa_pkg.sv
package isa_pkg;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_EXCP
    } op_class_e;

    // Code 11 is unassigned
    typedef enum logic [3:0] {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_NOR    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_ADD    = 4'd4,
        ALU_SUB    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_SLT    = 4'd9,
        ALU_SLTU   = 4'd10,
        ALU_PASS_B = 4'd12 // Operand 2 straight through
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW,
        MEM_NONE
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_B, BR_BL, BR_JIRL,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    // Ecode values of the exceptions that survive decode
    typedef enum logic [5:0] {
        EXC_NONE = 6'h00,
        EXC_ADEF = 6'h08, // Fetch address not word aligned
        EXC_SYS  = 6'h0b,
        EXC_BRK  = 6'h0c,
        EXC_INE  = 6'h0d  // Unknown or unsupported encoding
    } excp_code_e;

endpackage

// File: src/pipe_pkg.sv
`include "decode_macros.svh"

package pipe_pkg;

    // One decoded instruction as it leaves the decoder
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       imm;       // Already extended and shifted
        isa_pkg::op_class_e     op_class;
        isa_pkg::alu_op_e       alu_op;
        isa_pkg::mem_op_e       mem_op;
        isa_pkg::br_op_e        br_op;
        logic [`GPR_W-1:0]      rj;
        logic [`GPR_W-1:0]      rk;
        logic [`GPR_W-1:0]      rd;        // Also store data and branch operand
        logic                   reg_write;
        logic                   src1_pc;   // Operand 1 is pc instead of rj
        logic                   src2_imm;  // Operand 2 is imm instead of rk
        isa_pkg::excp_code_e    excp;
    } decoded_op_t;

    // Record handed to the execute side
    typedef struct packed {
        decoded_op_t            op;
        logic [`XLEN-1:0]       branch_target; // Zero for non-branches
        logic [`XLEN-1:0]       link_addr;
    } dispatch_t;

endpackage

// File: src/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module inst_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_valid,
    input  logic [`XLEN-1:0]        fetch_pc,
    input  logic [`XLEN-1:0]        fetch_inst,
    output logic                    fetch_ready,
    output logic                    push,
    output pipe_pkg::decoded_op_t   push_data,
    input  logic                    credit_ret
);

    localparam int CNT_W = $clog2(`DQ_DEPTH + 1);

    logic [CNT_W-1:0]       credit_cnt;
    logic [`XLEN-1:0]       ir;
    logic [`XLEN-1:0]       imm12_s;
    logic [`XLEN-1:0]       imm12_u;
    logic [`XLEN-1:0]       imm16_br;
    logic [`XLEN-1:0]       imm26_br;
    isa_pkg::excp_code_e    code;
    pipe_pkg::decoded_op_t  dec;

    function automatic pipe_pkg::decoded_op_t excp_op(input logic [`XLEN-1:0] pc,
                                                      input isa_pkg::excp_code_e ecode);
        pipe_pkg::decoded_op_t op;
        op          = '0;
        op.pc       = pc;
        op.op_class = isa_pkg::OP_EXCP;
        op.alu_op   = isa_pkg::ALU_AND;
        op.mem_op   = isa_pkg::MEM_NONE;
        op.br_op    = isa_pkg::BR_NONE;
        op.excp     = ecode;
        return op;
    endfunction

    assign ir       = fetch_inst;
    assign imm12_s  = {{(`XLEN-12){ir[21]}}, ir[21:10]};
    assign imm12_u  = {{(`XLEN-12){1'b0}}, ir[21:10]};
    assign imm16_br = {{(`XLEN-18){ir[25]}}, ir[25:10], 2'b00};
    assign imm26_br = {{(`XLEN-28){ir[9]}}, ir[9:0], ir[25:10], 2'b00};

    always_comb
    begin
        dec          = excp_op(fetch_pc, isa_pkg::EXC_NONE);
        dec.op_class = isa_pkg::OP_ALU;
        code         = isa_pkg::EXC_NONE;
        case (ir[31:26])
            6'b000000:
                case (ir[25:22])
                    4'b0000:
                    begin
                        dec.rk        = ir[14:10];
                        dec.rj        = ir[9:5];
                        dec.rd        = ir[4:0];
                        dec.reg_write = 1'b1;
                        case (ir[21:15])
                            7'b0100000: dec.alu_op = isa_pkg::ALU_ADD;
                            7'b0100010: dec.alu_op = isa_pkg::ALU_SUB;
                            7'b0100100: dec.alu_op = isa_pkg::ALU_SLT;
                            7'b0100101: dec.alu_op = isa_pkg::ALU_SLTU;
                            7'b0101000: dec.alu_op = isa_pkg::ALU_NOR;
                            7'b0101001: dec.alu_op = isa_pkg::ALU_AND;
                            7'b0101010: dec.alu_op = isa_pkg::ALU_OR;
                            7'b0101011: dec.alu_op = isa_pkg::ALU_XOR;
                            7'b0101110: dec.alu_op = isa_pkg::ALU_SLL;
                            7'b0101111: dec.alu_op = isa_pkg::ALU_SRL;
                            7'b0110000: dec.alu_op = isa_pkg::ALU_SRA;
                            7'b1010100: code = isa_pkg::EXC_BRK;
                            7'b1010110: code = isa_pkg::EXC_SYS;
                            default:    code = isa_pkg::EXC_INE; // Mul, div, rdcnt land here
                        endcase
                    end
                    4'b0001:
                    begin
                        dec.imm       = {{(`XLEN-5){1'b0}}, ir[14:10]}; // Shift amount
                        dec.rj        = ir[9:5];
                        dec.rd        = ir[4:0];
                        dec.reg_write = 1'b1;
                        dec.src2_imm  = 1'b1;
                        if (ir[21:20] != 2'b00 || ir[17:15] != 3'b001)
                            code = isa_pkg::EXC_INE;
                        else
                            case (ir[19:18])
                                2'b00:   dec.alu_op = isa_pkg::ALU_SLL;
                                2'b01:   dec.alu_op = isa_pkg::ALU_SRL;
                                2'b10:   dec.alu_op = isa_pkg::ALU_SRA;
                                default: code = isa_pkg::EXC_INE;
                            endcase
                    end
                    4'b1000, 4'b1001, 4'b1010, 4'b1101, 4'b1110, 4'b1111:
                    begin
                        dec.imm       = ir[24] ? imm12_u : imm12_s; // Logic ops zero extend
                        dec.rj        = ir[9:5];
                        dec.rd        = ir[4:0];
                        dec.reg_write = 1'b1;
                        dec.src2_imm  = 1'b1;
                        case (ir[24:22])
                            3'b000:  dec.alu_op = isa_pkg::ALU_SLT;
                            3'b001:  dec.alu_op = isa_pkg::ALU_SLTU;
                            3'b010:  dec.alu_op = isa_pkg::ALU_ADD;
                            3'b101:  dec.alu_op = isa_pkg::ALU_AND;
                            3'b110:  dec.alu_op = isa_pkg::ALU_OR;
                            default: dec.alu_op = isa_pkg::ALU_XOR;
                        endcase
                    end
                    default: code = isa_pkg::EXC_INE;
                endcase
            6'b000101, 6'b000111: // LU12I.W, PCADDU12I
            begin
                dec.imm       = {ir[24:5], 12'b0};
                dec.rd        = ir[4:0];
                dec.reg_write = 1'b1;
                dec.src2_imm  = 1'b1;
                dec.src1_pc   = ir[27];
                dec.alu_op    = ir[27] ? isa_pkg::ALU_ADD : isa_pkg::ALU_PASS_B;
                if (ir[25])
                    code = isa_pkg::EXC_INE;
            end
            6'b001010:
            begin
                dec.imm       = imm12_s;
                dec.rj        = ir[9:5];
                dec.rd        = ir[4:0];
                dec.alu_op    = isa_pkg::ALU_ADD; // Address add
                dec.src2_imm  = 1'b1;
                dec.op_class  = ir[24] ? isa_pkg::OP_STORE : isa_pkg::OP_LOAD;
                dec.reg_write = !ir[24];
                case (ir[25:22])
                    4'b0000: dec.mem_op = isa_pkg::MEM_LB;
                    4'b0001: dec.mem_op = isa_pkg::MEM_LH;
                    4'b0010: dec.mem_op = isa_pkg::MEM_LW;
                    4'b0100: dec.mem_op = isa_pkg::MEM_SB;
                    4'b0101: dec.mem_op = isa_pkg::MEM_SH;
                    4'b0110: dec.mem_op = isa_pkg::MEM_SW;
                    4'b1000: dec.mem_op = isa_pkg::MEM_LBU;
                    4'b1001: dec.mem_op = isa_pkg::MEM_LHU;
                    default: code = isa_pkg::EXC_INE; // PRELD included
                endcase
            end
            6'b010011: // JIRL
            begin
                dec.op_class  = isa_pkg::OP_BRANCH;
                dec.br_op     = isa_pkg::BR_JIRL;
                dec.imm       = imm16_br;
                dec.rj        = ir[9:5];
                dec.rd        = ir[4:0];
                dec.reg_write = 1'b1;
                dec.alu_op    = isa_pkg::ALU_ADD;
                dec.src1_pc   = 1'b1;
            end
            6'b010100: // B
            begin
                dec.op_class = isa_pkg::OP_BRANCH;
                dec.br_op    = isa_pkg::BR_B;
                dec.imm      = imm26_br;
            end
            6'b010101: // BL
            begin
                dec.op_class  = isa_pkg::OP_BRANCH;
                dec.br_op     = isa_pkg::BR_BL;
                dec.imm       = imm26_br;
                dec.rd        = `GPR_W'd1; // Return address register
                dec.reg_write = 1'b1;
                dec.alu_op    = isa_pkg::ALU_ADD;
                dec.src1_pc   = 1'b1;
            end
            6'b010110, 6'b010111, 6'b011000, 6'b011001, 6'b011010, 6'b011011:
            begin
                dec.op_class = isa_pkg::OP_BRANCH;
                dec.imm      = imm16_br;
                dec.rj       = ir[9:5];
                dec.rd       = ir[4:0];
                case (ir[28:26])
                    3'b110:  dec.br_op = isa_pkg::BR_BEQ;
                    3'b111:  dec.br_op = isa_pkg::BR_BNE;
                    3'b000:  dec.br_op = isa_pkg::BR_BLT;
                    3'b001:  dec.br_op = isa_pkg::BR_BGE;
                    3'b010:  dec.br_op = isa_pkg::BR_BLTU;
                    default: dec.br_op = isa_pkg::BR_BGEU;
                endcase
                if (ir[28])
                    dec.alu_op = isa_pkg::ALU_SUB; // Equality compare
                else
                    dec.alu_op = ir[27] ? isa_pkg::ALU_SLTU : isa_pkg::ALU_SLT;
            end
            default: code = isa_pkg::EXC_INE; // CSR, TLB, atomics, barriers
        endcase
        if (|fetch_pc[1:0])
            dec = excp_op(fetch_pc, isa_pkg::EXC_ADEF); // Beats any decode result
        else if (code != isa_pkg::EXC_NONE)
            dec = excp_op(fetch_pc, code);
    end

    assign fetch_ready = (credit_cnt != '0);
    assign push        = fetch_valid && fetch_ready;
    assign push_data   = dec;

    always_ff @(posedge clk)
    begin
        if (reset)
            credit_cnt <= CNT_W'(`DQ_DEPTH);
        else
            credit_cnt <= credit_cnt - CNT_W'(push) + CNT_W'(credit_ret);
    end

    // Queue must never hand back more credits than were spent
    credit_bound_a: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= CNT_W'(`DQ_DEPTH))
        else $error("decoder credit count above queue depth");

endmodule

// File: src/credit_queue.sv
`timescale 1ns/1ps

module credit_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    output logic     head_valid,
    output payload_t head,
    input  logic     pop,
    output logic     credit_ret
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            count      <= count + CNT_W'(push) - CNT_W'(pop);
            credit_ret <= pop; // One credit per departing entry
        end
    end

    // Sender credits must keep it from overrunning the buffer
    no_overflow_a: assert property (@(posedge clk) disable iff (reset)
        push |-> (count < CNT_W'(DEPTH)))
        else $error("push into full queue");

    no_underflow_a: assert property (@(posedge clk) disable iff (reset)
        pop |-> head_valid)
        else $error("pop from empty queue");

endmodule

// File: src/dispatch_stage.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module dispatch_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    head_valid,
    input  pipe_pkg::decoded_op_t   head,
    output logic                    pop,
    input  logic                    exec_credit,
    output logic                    disp_valid,
    output pipe_pkg::dispatch_t     disp
);

    localparam int EC_W = $clog2(`EXEC_CREDITS + 1);

    logic [EC_W-1:0]    ec_cnt;
    logic               is_branch;
    logic [`XLEN-1:0]   target_sum;
    logic [`XLEN-1:0]   link_sum;

    assign pop = head_valid && (ec_cnt != '0);

    // JIRL adds its rj base later in execute
    assign is_branch  = (head.op_class == isa_pkg::OP_BRANCH);
    assign target_sum = head.pc + head.imm;
    assign link_sum   = head.pc + `XLEN'(4);

    always_ff @(posedge clk)
    begin
        if (reset)
            ec_cnt <= EC_W'(`EXEC_CREDITS);
        else
            ec_cnt <= ec_cnt - EC_W'(pop) + EC_W'(exec_credit);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            disp_valid <= 1'b0;
        else
            disp_valid <= pop;
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            disp.op            <= head;
            disp.branch_target <= is_branch ? target_sum : '0;
            disp.link_addr     <= link_sum;
        end
    end

    // Execute side may only return credits it was given
    exec_credit_bound_a: assert property (@(posedge clk) disable iff (reset)
        ec_cnt <= EC_W'(`EXEC_CREDITS))
        else $error("execute credit count above limit");

endmodule

// File: src/decode_top.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_valid,
    input  logic [`XLEN-1:0]        fetch_pc,
    input  logic [`XLEN-1:0]        fetch_inst,
    output logic                    fetch_ready,
    input  logic                    exec_credit,
    output logic                    disp_valid,
    output pipe_pkg::dispatch_t     disp
);

    logic                   push;
    pipe_pkg::decoded_op_t  push_data;
    logic                   credit_ret;
    logic                   head_valid;
    pipe_pkg::decoded_op_t  head;
    logic                   pop;

    inst_decoder decoder_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .fetch_ready (fetch_ready),
        .push        (push),
        .push_data   (push_data),
        .credit_ret  (credit_ret)
    );

    credit_queue #(
        .payload_t (pipe_pkg::decoded_op_t),
        .DEPTH     (`DQ_DEPTH)
    ) queue_i (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_data  (push_data),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .credit_ret (credit_ret)
    );

    dispatch_stage dispatch_i (
        .clk         (clk),
        .reset       (reset),
        .head_valid  (head_valid),
        .head        (head),
        .pop         (pop),
        .exec_credit (exec_credit),
        .disp_valid  (disp_valid),
        .disp        (disp)
    );

endmodule

// File: verification/ref_decode.svh
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

// Instruction groups used by the stimulus
localparam int G_RR   = 0;
localparam int G_SHI  = 1;
localparam int G_I12  = 2;
localparam int G_U20  = 3;
localparam int G_MEM  = 4;
localparam int G_BR   = 5;
localparam int G_TRAP = 6;
localparam int G_ILL  = 7;

localparam int GRP_SIZE [8] = '{11, 3, 6, 2, 8, 9, 2, 6};

localparam logic [16:0] RR_OPC [11] = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29,
                                        17'h2a, 17'h2b, 17'h2e, 17'h2f, 17'h30};
localparam logic [16:0] SHI_OPC [3] = '{17'h81, 17'h89, 17'h91};
localparam logic [9:0]  I12_OPC [6] = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f};
localparam logic [6:0]  U20_OPC [2] = '{7'h0a, 7'h0e}; // LU12I.W, PCADDU12I
localparam logic [9:0]  MEM_OPC [8] = '{10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9,
                                        10'h0a4, 10'h0a5, 10'h0a6}; // Loads first
localparam logic [5:0]  BR_OPC [9]  = '{6'h13, 6'h14, 6'h15, 6'h16, 6'h17, 6'h18,
                                        6'h19, 6'h1a, 6'h1b};
localparam logic [16:0] TRAP_OPC [2] = '{17'h56, 17'h54}; // SYSCALL, BREAK

localparam isa_pkg::alu_op_e RR_ALU [11] = '{
    isa_pkg::ALU_ADD, isa_pkg::ALU_SUB, isa_pkg::ALU_SLT, isa_pkg::ALU_SLTU,
    isa_pkg::ALU_NOR, isa_pkg::ALU_AND, isa_pkg::ALU_OR, isa_pkg::ALU_XOR,
    isa_pkg::ALU_SLL, isa_pkg::ALU_SRL, isa_pkg::ALU_SRA};
localparam isa_pkg::alu_op_e SHI_ALU [3] = '{isa_pkg::ALU_SLL, isa_pkg::ALU_SRL, isa_pkg::ALU_SRA};
localparam isa_pkg::alu_op_e I12_ALU [6] = '{
    isa_pkg::ALU_SLT, isa_pkg::ALU_SLTU, isa_pkg::ALU_ADD,
    isa_pkg::ALU_AND, isa_pkg::ALU_OR, isa_pkg::ALU_XOR};
localparam isa_pkg::mem_op_e MEM_KIND [8] = '{
    isa_pkg::MEM_LB, isa_pkg::MEM_LH, isa_pkg::MEM_LW, isa_pkg::MEM_LBU,
    isa_pkg::MEM_LHU, isa_pkg::MEM_SB, isa_pkg::MEM_SH, isa_pkg::MEM_SW};
localparam isa_pkg::br_op_e BR_KIND [9] = '{
    isa_pkg::BR_JIRL, isa_pkg::BR_B, isa_pkg::BR_BL, isa_pkg::BR_BEQ, isa_pkg::BR_BNE,
    isa_pkg::BR_BLT, isa_pkg::BR_BGE, isa_pkg::BR_BLTU, isa_pkg::BR_BGEU};

function automatic pipe_pkg::dispatch_t ref_decode(input int grp, input int idx,
                                                   input logic [31:0] pc,
                                                   input logic [31:0] inst);
    pipe_pkg::dispatch_t e;
    logic [31:0]         sext12;
    logic [31:0]         offs;
    e      = '0;
    sext12 = {{20{inst[21]}}, inst[21:10]};
    offs   = (idx == 1 || idx == 2) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                                    : {{14{inst[25]}}, inst[25:10], 2'b00}; // B and BL take 26 bits
    e.op.pc        = pc;
    e.op.op_class  = isa_pkg::OP_ALU;
    e.op.mem_op    = isa_pkg::MEM_NONE;
    e.op.br_op     = isa_pkg::BR_NONE;
    e.op.excp      = isa_pkg::EXC_NONE;
    e.op.rj        = inst[9:5];
    e.op.rd        = inst[4:0];
    e.op.reg_write = 1'b1;
    e.link_addr    = pc + 32'd4;
    case (grp)
        G_RR:
        begin
            e.op.rk     = inst[14:10];
            e.op.alu_op = RR_ALU[idx];
        end
        G_SHI:
        begin
            e.op.alu_op   = SHI_ALU[idx];
            e.op.imm      = {27'b0, inst[14:10]};
            e.op.src2_imm = 1'b1;
        end
        G_I12:
        begin
            e.op.alu_op   = I12_ALU[idx];
            e.op.imm      = (idx < 3) ? sext12 : {20'b0, inst[21:10]};
            e.op.src2_imm = 1'b1;
        end
        G_U20:
        begin
            e.op.rj       = '0;
            e.op.alu_op   = (idx == 1) ? isa_pkg::ALU_ADD : isa_pkg::ALU_PASS_B;
            e.op.src1_pc  = (idx == 1);
            e.op.imm      = {inst[24:5], 12'b0};
            e.op.src2_imm = 1'b1;
        end
        G_MEM:
        begin
            e.op.op_class  = (idx < 5) ? isa_pkg::OP_LOAD : isa_pkg::OP_STORE;
            e.op.mem_op    = MEM_KIND[idx];
            e.op.imm       = sext12;
            e.op.reg_write = (idx < 5);
        end
        G_BR:
        begin
            e.op.op_class  = isa_pkg::OP_BRANCH;
            e.op.br_op     = BR_KIND[idx];
            e.op.reg_write = (idx == 0 || idx == 2); // JIRL and BL link
            e.branch_target = pc + offs;
            if (idx == 1 || idx == 2)
            begin
                e.op.rj = '0;
                e.op.rd = (idx == 2) ? 5'd1 : 5'd0;
            end
        end
        G_TRAP:  e.op.excp = (idx == 0) ? isa_pkg::EXC_SYS : isa_pkg::EXC_BRK;
        default: e.op.excp = isa_pkg::EXC_INE;
    endcase
    if (pc[1:0] != 2'b00)
        e.op.excp = isa_pkg::EXC_ADEF;
    if (e.op.excp != isa_pkg::EXC_NONE)
    begin
        e.op.op_class   = isa_pkg::OP_EXCP;
        e.op.mem_op     = isa_pkg::MEM_NONE;
        e.op.br_op      = isa_pkg::BR_NONE;
        e.op.reg_write  = 1'b0;
        e.branch_target = '0;
    end
    return e;
endfunction

`endif

// File: verification/decode_tb.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_tb;

    localparam int NUM_INSTS      = 300;
    localparam int TIMEOUT_CYCLES = 40 * NUM_INSTS;
    localparam int DRAIN_LIMIT    = 64 * (`DQ_DEPTH + `EXEC_CREDITS);

    `include "ref_decode.svh"

    logic                   clk;
    logic                   reset;
    logic                   fetch_valid;
    logic [`XLEN-1:0]       fetch_pc;
    logic [`XLEN-1:0]       fetch_inst;
    logic                   fetch_ready;
    logic                   exec_credit;
    logic                   disp_valid;
    pipe_pkg::dispatch_t    disp;
    pipe_pkg::dispatch_t    expected_q [$];
    logic [31:0]            rng;
    logic                   saw_stall;
    int                     cycles;
    int                     drain_cycles;
    int                     accepted_cnt;
    int                     taken_seen;
    int                     issued;
    int                     outstanding; // Dispatched but not yet credited back
    int                     cur_grp;
    int                     cur_idx;
    int                     value_errors;
    int                     protocol_errors;

    decode_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .fetch_ready (fetch_ready),
        .exec_credit (exec_credit),
        .disp_valid  (disp_valid),
        .disp        (disp)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] encode_inst(input int grp, input int idx,
                                                input logic [31:0] f);
        case (grp)
            G_RR:   return {RR_OPC[idx], f[14:0]};
            G_SHI:  return {SHI_OPC[idx], f[14:0]};
            G_I12:  return {I12_OPC[idx], f[21:0]};
            G_U20:  return {U20_OPC[idx], f[24:0]};
            G_MEM:  return {MEM_OPC[idx], f[21:0]};
            G_BR:   return {BR_OPC[idx], f[25:0]};
            G_TRAP: return {TRAP_OPC[idx], f[14:0]};
            default:
                case (idx)
                    0:       return {17'h38, f[14:0]};  // MUL.W
                    1:       return {17'h40, f[14:0]};  // DIV.W
                    2:       return {8'h04, f[23:0]};   // CSR access
                    3:       return {8'h20, f[23:0]};   // LL.W
                    4:       return {10'h0ab, f[21:0]}; // PRELD
                    default: return {2'b11, f[29:0]};   // Unused major opcode
                endcase
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_dispatch(input pipe_pkg::dispatch_t got,
                                    input pipe_pkg::dispatch_t exp);
        check_field("pc", got.op.pc, exp.op.pc);
        check_field("op_class", 32'(got.op.op_class), 32'(exp.op.op_class));
        check_field("excp", 32'(got.op.excp), 32'(exp.op.excp));
        check_field("mem_op", 32'(got.op.mem_op), 32'(exp.op.mem_op));
        check_field("br_op", 32'(got.op.br_op), 32'(exp.op.br_op));
        check_field("reg_write", 32'(got.op.reg_write), 32'(exp.op.reg_write));
        check_field("branch_target", got.branch_target, exp.branch_target);
        check_field("link_addr", got.link_addr, exp.link_addr);
        if (exp.op.op_class != isa_pkg::OP_EXCP)
        begin
            check_field("rj", 32'(got.op.rj), 32'(exp.op.rj));
            check_field("rk", 32'(got.op.rk), 32'(exp.op.rk));
            check_field("rd", 32'(got.op.rd), 32'(exp.op.rd));
        end
        if (exp.op.op_class == isa_pkg::OP_ALU)
        begin
            check_field("alu_op", 32'(got.op.alu_op), 32'(exp.op.alu_op));
            check_field("src1_pc", 32'(got.op.src1_pc), 32'(exp.op.src1_pc));
            check_field("src2_imm", 32'(got.op.src2_imm), 32'(exp.op.src2_imm));
        end
        if (exp.op.op_class inside {isa_pkg::OP_ALU, isa_pkg::OP_LOAD, isa_pkg::OP_STORE})
            check_field("imm", got.op.imm, exp.op.imm);
    endtask

    task automatic check_reset_state();
        assert (fetch_ready && !disp_valid && !dut_i.credit_ret && !dut_i.head_valid)
        else
        begin
            protocol_errors++;
            $display("outputs not in their reset state after reset at %0t", $time);
        end
    endtask

    task automatic present_next();
        logic [31:0] sel;
        logic [31:0] fields;
        logic [31:0] pc_bits;
        rng = xorshift(rng);
        sel = rng;
        rng = xorshift(rng);
        fields = rng;
        rng = xorshift(rng);
        pc_bits = rng;
        cur_grp     = int'(sel[2:0]);
        cur_idx     = int'(sel[15:8]) % GRP_SIZE[cur_grp];
        fetch_inst  = encode_inst(cur_grp, cur_idx, fields);
        fetch_pc    = {pc_bits[31:2], (sel[23:20] == 4'h0) ? pc_bits[1:0] : 2'b00};
        fetch_valid = 1'b1;
        issued++;
    endtask

    // Credits held back for 24 of every 64 cycles
    task automatic drive_credit();
        rng = xorshift(rng);
        exec_credit = (outstanding > 0) && (cycles % 64 < 40) && (rng[1:0] != 2'b00);
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, %0d of %0d instructions accepted",
                     cycles, accepted_cnt, NUM_INSTS);
            $display("STATUS: FAIL");
            $finish;
        end
        else if (!reset)
        begin
            if (fetch_valid && fetch_ready)
            begin
                expected_q.push_back(ref_decode(cur_grp, cur_idx, fetch_pc, fetch_inst));
                accepted_cnt++;
            end
            if (!fetch_ready)
                saw_stall = 1'b1;
            if (disp_valid)
            begin
                assert (expected_q.size() != 0)
                else
                begin
                    protocol_errors++;
                    $display("dispatch at %0t with no accepted instruction pending", $time);
                end
                if (expected_q.size() != 0)
                    compare_dispatch(disp, expected_q.pop_front());
            end
            outstanding = outstanding + int'(disp_valid) - int'(exec_credit);
            assert (outstanding <= `EXEC_CREDITS)
            else
            begin
                protocol_errors++;
                $display("%0d dispatches outstanding at %0t", outstanding, $time);
            end
        end
    end

    initial
    begin
        clk             = 1'b0;
        reset           = 1'b1;
        fetch_valid     = 1'b0;
        fetch_pc        = '0;
        fetch_inst      = '0;
        exec_credit     = 1'b0;
        rng             = 32'hfa00;
        saw_stall       = 1'b0;
        cycles          = 0;
        drain_cycles    = 0;
        accepted_cnt    = 0;
        taken_seen      = 0;
        issued          = 0;
        outstanding     = 0;
        cur_grp         = 0;
        cur_idx         = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        while (accepted_cnt < NUM_INSTS)
        begin
            @(posedge clk);
            #1;
            drive_credit();
            if (accepted_cnt != taken_seen) // Taken at the last edge
            begin
                taken_seen  = accepted_cnt;
                fetch_valid = 1'b0;
            end
            rng = xorshift(rng);
            if (!fetch_valid && issued < NUM_INSTS && rng[1:0] != 2'b00)
                present_next();
        end
        while (expected_q.size() != 0 && drain_cycles < DRAIN_LIMIT)
        begin
            @(posedge clk);
            #1;
            drive_credit();
            drain_cycles++;
        end
        repeat (4)
        begin
            @(posedge clk);
            #1;
            drive_credit();
        end
        assert (expected_q.size() == 0)
        else
        begin
            protocol_errors++;
            $display("%0d records never dispatched", expected_q.size());
        end
        assert (saw_stall)
        else
        begin
            protocol_errors++;
            $display("fetch_ready never dropped while execute credits were held back");
        end
        $display("errors: value=%0d protocol=%0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: sim.f
+incdir+src
+incdir+verification
src/isa_pkg.sv
src/pipe_pkg.sv
src/inst_decoder.sv
src/credit_queue.sv
src/dispatch_stage.sv
src/decode_top.sv
verification/decode_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = decode_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
